// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_video
FILELIST = tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(TOOL)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: audio/audio_conditioner.sv
// audio saturation, volume and mix
`timescale 1ns/1ps
`include "video_params.svh"

module audio_conditioner (
   input  logic               clk,
   input  logic [17:0]        audio_l,
   input  logic [17:0]        audio_r,
   input  audio_pkg::volume_t volume,
   output audio_pkg::sample_t sample
);
   import audio_pkg::*;

   sample_t            chan_l;
   sample_t            chan_r;
   sample_t            vol_l;
   sample_t            vol_r;
   logic signed [16:0] mix;
   logic signed [16:0] mix_att;

   // drop two low bits and clip to a symmetric 16-bit range
   function automatic sample_t clip(input logic [17:0] a);
      sample_t t;
      t = sample_t'(a[17:2]);
      if (t == 16'sh8000) begin
         clip = 16'sh8001;
      end else begin
         clip = t;
      end
   endfunction

   function automatic sample_t scale(input sample_t s, input volume_t v);
      case (v)
         VOL_MUTE:    scale = '0;
         VOL_QUARTER: scale = s >>> 2;
         VOL_HALF:    scale = s >>> 1;
         default:     scale = s;
      endcase
   endfunction

   assign vol_l   = scale(chan_l, volume);
   assign vol_r   = scale(chan_r, volume);
   // sign extend, then sum
   assign mix     = {vol_l[15], vol_l} + {vol_r[15], vol_r};
   assign mix_att = mix >>> `AUDIO_SHIFT;

   always_ff @(posedge clk) begin
      chan_l <= clip(audio_l);
      chan_r <= clip(audio_r);
      sample <= sample_t'(mix_att[15:0]);
   end

endmodule

// File: audio/i2s_tx.sv
// i2s transmitter
`timescale 1ns/1ps
`include "video_params.svh"

module i2s_tx (
   input  logic               clk,
   input  logic               pll_lock,
   input  logic               ntscmode,
   input  audio_pkg::sample_t sample,
   output logic               bck,
   output logic               ws,
   output logic               din
);
   import audio_pkg::*;

   localparam logic [4:0] DIV_PAL  = 5'(`I2S_DIV_PAL);
   localparam logic [4:0] DIV_NTSC = 5'(`I2S_DIV_NTSC);

   logic [4:0] div_cnt;
   logic [4:0] div_max;
   logic       bck_q;
   logic       bck_fall;
   logic [4:0] bit_cnt;
   sample_t    word;

   assign div_max  = ntscmode ? DIV_NTSC : DIV_PAL;
   // high to low transition of the bit clock
   assign bck_fall = (div_cnt == div_max) && bck_q;

   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         div_cnt <= '0;
         bck_q   <= 1'b0;
         bit_cnt <= '0;
         word    <= '0;
      end else begin
         if (div_cnt == div_max) begin
            div_cnt <= '0;
            bck_q   <= ~bck_q;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         if (bck_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            // hold the word for both halves of the frame
            if (bit_cnt == 5'd31) begin
               word <= sample;
            end
         end
      end
   end

   assign bck = bck_q;
   assign ws  = bit_cnt[4];
   // msb first, inverted count gives 15 down to 0
   assign din = word[~bit_cnt[3:0]];

endmodule

// File: common/audio_pkg.sv
// audio path types
package audio_pkg;

   // user volume, as set in the menu
   typedef enum logic [1:0] {
      VOL_MUTE    = 2'd0,
      VOL_QUARTER = 2'd1,
      VOL_HALF    = 2'd2,
      VOL_FULL    = 2'd3
   } volume_t;

   // one i2s word
   typedef logic signed [15:0] sample_t;

endpackage

// File: common/pixel_if.sv
// pixel bus
`timescale 1ns/1ps

interface pixel_if;
   logic       hs_n;
   logic       vs_n;
   logic [5:0] r;
   logic [5:0] g;
   logic [5:0] b;

   modport src (
      output hs_n, vs_n, r, g, b
   );

   modport snk (
      input hs_n, vs_n, r, g, b
   );
endinterface

// File: common/video_params.svh
// video and audio output constants
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// line buffer, one half per input line
`define LINE_ADDR_W 11

// panel counter preloads at end of sync
`define DE_X_PAL   1880
`define DE_Y_PAL   940
`define DE_X_NTSC  1850
`define DE_Y_NTSC  980

// active panel window
`define DE_WIDTH   800
`define DE_HEIGHT  480

// i2s bit clock half period in clk, minus one
`define I2S_DIV_PAL   19
`define I2S_DIV_NTSC  20

// final attenuation of the mono mix
`define AUDIO_SHIFT 2

// osd window, origin after end of sync, one bit per pixel
`define OSD_X0 16
`define OSD_Y0 8
`define OSD_W  64
`define OSD_H  16

`endif

// File: common/video_pkg.sv
// video path types
package video_pkg;

   // dimming of the repeated line
   typedef enum logic [1:0] {
      SCAN_NONE = 2'd0,
      SCAN_25   = 2'd1,
      SCAN_50   = 2'd2,
      SCAN_75   = 2'd3
   } scanline_t;

   // first byte after mcu_start
   typedef enum logic [7:0] {
      OSD_CMD_DISABLE = 8'h00,
      OSD_CMD_ENABLE  = 8'h01,
      OSD_CMD_WRITE   = 8'h02
   } osd_cmd_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_CMD,
      RX_DATA
   } osd_rx_state_t;

endpackage

// File: source/video.sv
// video and audio output top
`timescale 1ns/1ps

module video (
   input  logic        clk,
   input  logic        pll_lock,
   input  logic        ntscmode,
   input  logic        vs_in_n,
   input  logic        hs_in_n,
   input  logic [3:0]  r_in,
   input  logic [3:0]  g_in,
   input  logic [3:0]  b_in,
   input  logic [17:0] audio_l,
   input  logic [17:0] audio_r,
   input  logic        mcu_start,
   input  logic        mcu_osd_strobe,
   input  logic [7:0]  mcu_data,
   input  logic [1:0]  system_scanlines,
   input  logic [1:0]  system_volume,
   output logic        osd_status,
   output logic        lcd_clk,
   output logic        lcd_hs_n,
   output logic        lcd_vs_n,
   output logic        lcd_de,
   output logic [5:0]  lcd_r,
   output logic [5:0]  lcd_g,
   output logic [5:0]  lcd_b,
   output logic        lcd_bl,
   output logic        hp_bck,
   output logic        hp_ws,
   output logic        hp_din,
   output logic        pa_en
);
   import video_pkg::*;
   import audio_pkg::*;

   pixel_if sd_pix ();
   pixel_if osd_pix ();

   sample_t mix_sample;

   scandoubler scandoubler_inst (
      .clk       (clk),
      .pll_lock  (pll_lock),
      .scanlines (scanline_t'(system_scanlines)),
      .hs_in_n   (hs_in_n),
      .vs_in_n   (vs_in_n),
      .r_in      (r_in),
      .g_in      (g_in),
      .b_in      (b_in),
      .pix_out   (sd_pix.src)
   );

   osd_overlay osd_overlay_inst (
      .clk            (clk),
      .pll_lock       (pll_lock),
      .data_in_start  (mcu_start),
      .data_in_strobe (mcu_osd_strobe),
      .data_in        (mcu_data),
      .pix_in         (sd_pix.snk),
      .pix_out        (osd_pix.src),
      .osd_status     (osd_status)
   );

   lcd_de_gen lcd_de_gen_inst (
      .clk      (clk),
      .ntscmode (ntscmode),
      .hs_n     (osd_pix.hs_n),
      .vs_n     (osd_pix.vs_n),
      .de       (lcd_de)
   );

   audio_conditioner audio_conditioner_inst (
      .clk     (clk),
      .audio_l (audio_l),
      .audio_r (audio_r),
      .volume  (volume_t'(system_volume)),
      .sample  (mix_sample)
   );

   i2s_tx i2s_tx_inst (
      .clk      (clk),
      .pll_lock (pll_lock),
      .ntscmode (ntscmode),
      .sample   (mix_sample),
      .bck      (hp_bck),
      .ws       (hp_ws),
      .din      (hp_din)
   );

   // panel runs on the pixel clock
   assign lcd_clk  = clk;
   assign lcd_hs_n = osd_pix.hs_n;
   assign lcd_vs_n = osd_pix.vs_n;
   assign lcd_r    = osd_pix.r;
   assign lcd_g    = osd_pix.g;
   assign lcd_b    = osd_pix.b;

   // backlight on and amplifier enabled (low) once the pll is locked
   assign lcd_bl = pll_lock;
   assign pa_en  = ~pll_lock;

endmodule

// File: tb.f
+incdir+common
common/video_pkg.sv
common/audio_pkg.sv
common/pixel_if.sv
video/scandoubler.sv
video/osd_overlay.sv
video/lcd_de_gen.sv
audio/audio_conditioner.sv
audio/i2s_tx.sv
source/video.sv
testbench/tb_video.sv

// File: testbench/tb_video.sv
// video output stage testbench
`timescale 1ns/1ps
`include "video_params.svh"

module tb_video;

   // input timing in clk cycles with two clk per input pixel
   localparam int H_TOTAL = 288;
   localparam int H_SYNC  = 32;
   localparam int V_TOTAL = 40;
   localparam int V_SYNC  = 3;
   localparam int ROWS    = 8;

   logic        clk;
   logic        pll_lock;
   logic        ntscmode;
   logic        vs_in_n;
   logic        hs_in_n;
   logic [3:0]  r_in;
   logic [3:0]  g_in;
   logic [3:0]  b_in;
   logic [17:0] audio_l;
   logic [17:0] audio_r;
   logic        mcu_start;
   logic        mcu_osd_strobe;
   logic [7:0]  mcu_data;
   logic [1:0]  system_scanlines;
   logic [1:0]  system_volume;
   logic        osd_status;
   logic        lcd_clk;
   logic        lcd_hs_n;
   logic        lcd_vs_n;
   logic        lcd_de;
   logic [5:0]  lcd_r;
   logic [5:0]  lcd_g;
   logic [5:0]  lcd_b;
   logic        lcd_bl;
   logic        hp_bck;
   logic        hp_ws;
   logic        hp_din;
   logic        pa_en;

   int          errors;
   int          seed;
   int          hcount;
   int          vcount;

   // stimulus table
   string       t_name  [0:ROWS-1];
   logic [1:0]  t_scan  [0:ROWS-1];
   logic [1:0]  t_vol   [0:ROWS-1];
   logic [17:0] t_left  [0:ROWS-1];
   logic [17:0] t_right [0:ROWS-1];
   logic [11:0] t_col   [0:ROWS-1];
   logic [17:0] t_exp1  [0:ROWS-1];
   logic [17:0] t_exp2  [0:ROWS-1];
   int          t_word  [0:ROWS-1];

   // i2s receiver state
   logic        rx_ws_prev;
   int          rx_bits;
   logic [15:0] rx_shift;
   logic [15:0] rx_left;
   logic [15:0] rx_right;
   int          word_count;

   video video_inst (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // 15 khz style sync with a short frame
   initial begin
      hcount  = 0;
      vcount  = 0;
      hs_in_n = 1'b1;
      vs_in_n = 1'b1;
      forever begin
         @(negedge clk);
         hs_in_n = (hcount >= H_SYNC);
         vs_in_n = (vcount >= V_SYNC);
         hcount  = hcount + 1;
         if (hcount == H_TOTAL) begin
            hcount = 0;
            vcount = (vcount + 1) % V_TOTAL;
         end
      end
   end

   initial begin
      rx_ws_prev = 1'b1;
      rx_bits    = 0;
      rx_shift   = '0;
      rx_left    = '0;
      rx_right   = '0;
      word_count = 0;
   end

   // bits taken on rising bck and grouped by ws
   always @(posedge hp_bck) begin
      if (hp_ws !== rx_ws_prev) begin
         rx_bits = 0;
      end
      rx_ws_prev = hp_ws;
      rx_shift   = {rx_shift[14:0], hp_din};
      rx_bits    = rx_bits + 1;
      if (rx_bits == 16) begin
         if (!hp_ws) begin
            rx_left = rx_shift;
         end else begin
            rx_right   = rx_shift;
            word_count = word_count + 1;
         end
      end
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("errors: %0d", errors + 1);
      $display("tests failed");
      $finish;
   endtask

   task automatic check_val(input string name, input logic signed [31:0] exp,
                            input logic signed [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("Fail %s: expected %0d, actual %0d", name, exp, got);
      end
   endtask

   function automatic logic pick(input int sel);
      case (sel)
         0:       pick = hs_in_n;
         1:       pick = lcd_hs_n;
         default: pick = lcd_vs_n;
      endcase
   endfunction

   // waits for a transition to level just after each falling edge
   task automatic wait_edge(input int sel, input logic level, input int limit,
                            input string what);
      int   n;
      logic prev;
      logic cur;
      logic seen;
      prev = pick(sel);
      seen = 1'b0;
      for (n = 0; n < limit && !seen; n++) begin
         @(negedge clk);
         #1;
         cur = pick(sel);
         if (cur === level && prev !== level) begin
            seen = 1'b1;
         end
         prev = cur;
      end
      if (!seen) begin
         abort_run({"timeout waiting for ", what});
      end
   endtask

   task automatic wait_words(input int n_words);
      int n;
      int target;
      target = word_count + n_words;
      for (n = 0; n < 8000 && word_count < target; n++) begin
         @(negedge clk);
      end
      if (word_count < target) begin
         abort_run("timeout waiting for i2s words");
      end
   endtask

   task automatic wait_status(input logic level);
      int n;
      for (n = 0; n < 100 && osd_status !== level; n++) begin
         @(negedge clk);
         #1;
      end
      if (osd_status !== level) begin
         abort_run("timeout waiting for osd_status");
      end
   endtask

   // start pulse then opcode and payload bytes
   task automatic send_osd(input logic [7:0] op, input int n_bytes);
      int i;
      @(negedge clk);
      mcu_start = 1'b1;
      @(negedge clk);
      mcu_start      = 1'b0;
      mcu_osd_strobe = 1'b1;
      mcu_data       = op;
      for (i = 0; i < n_bytes; i++) begin
         @(negedge clk);
         mcu_data = (i < 8) ? 8'hff : 8'h00;
      end
      @(negedge clk);
      mcu_osd_strobe = 1'b0;
   endtask

   // reference rule for one mixed sample
   function automatic int ref_word(input logic [17:0] a, input logic [17:0] b,
                                   input logic [1:0] v);
      int ch [0:1];
      int k;
      ch[0] = int'($signed(a)) >>> 2;
      ch[1] = int'($signed(b)) >>> 2;
      for (k = 0; k < 2; k++) begin
         if (ch[k] > 32767) ch[k] = 32767;
         if (ch[k] < -32767) ch[k] = -32767;
         case (v)
            2'd0: ch[k] = 0;
            2'd1: ch[k] = ch[k] >>> 2;
            2'd2: ch[k] = ch[k] >>> 1;
            default: ;
         endcase
      end
      ref_word = (ch[0] + ch[1]) >>> `AUDIO_SHIFT;
   endfunction

   // counter positions inside the window over a span of counts
   function automatic int de_hits(input int preload, input int span, input int modulo,
                                  input int limit);
      int k;
      de_hits = 0;
      for (k = 0; k < span; k++) begin
         if ((preload + k) % modulo < limit) de_hits++;
      end
   endfunction

   task automatic measure_de(output int cycles, output int lines);
      int   n;
      logic prev_hs;
      logic prev_vs;
      logic line_de;
      logic done;
      wait_edge(2, 1'b1, 20000, "output vsync");
      cycles  = 0;
      lines   = 0;
      line_de = 1'b0;
      done    = 1'b0;
      prev_hs = lcd_hs_n;
      prev_vs = lcd_vs_n;
      for (n = 0; n < 20000 && !done; n++) begin
         @(negedge clk);
         #1;
         if (lcd_de === 1'b1) begin
            cycles++;
            line_de = 1'b1;
         end
         if (lcd_hs_n && !prev_hs) begin
            if (line_de) lines++;
            line_de = 1'b0;
         end
         if (lcd_vs_n && !prev_vs) done = 1'b1;
         prev_hs = lcd_hs_n;
         prev_vs = lcd_vs_n;
      end
      if (!done) abort_run("timeout measuring a frame of lcd_de");
   endtask

   task automatic set_row(input int i, input string name, input logic [1:0] scan,
                          input logic [1:0] vol, input logic [17:0] left,
                          input logic [17:0] right, input logic [11:0] col,
                          input logic [17:0] exp1, input logic [17:0] exp2,
                          input int word);
      t_name[i]  = name;
      t_scan[i]  = scan;
      t_vol[i]   = vol;
      t_left[i]  = left;
      t_right[i] = right;
      t_col[i]   = col;
      t_exp1[i]  = exp1;
      t_exp2[i]  = exp2;
      t_word[i]  = word;
   endtask

   task automatic load_table();
      logic [17:0] a;
      logic [17:0] b;
      set_row(0, "scan_none", 2'd0, 2'd3, 18'sd1000, 18'sd2000, 12'hf84,
              {6'd63, 6'd34, 6'd17}, {6'd63, 6'd34, 6'd17}, 187);
      set_row(1, "scan_25", 2'd1, 2'd2, -18'sd4000, 18'sd800, 12'hc63,
              {6'd51, 6'd25, 6'd12}, {6'd39, 6'd19, 6'd9}, -100);
      set_row(2, "scan_50", 2'd2, 2'd1, 18'sd40000, -18'sd12000, 12'h9a5,
              {6'd38, 6'd42, 6'd21}, {6'd19, 6'd21, 6'd10}, 437);
      set_row(3, "scan_75", 2'd3, 2'd0, 18'sd50000, 18'sd50000, 12'hfff,
              {6'd63, 6'd63, 6'd63}, {6'd15, 6'd15, 6'd15}, 0);
      set_row(4, "sat_pos", 2'd0, 2'd3, 18'h1ffff, 18'h1ffff, 12'h000,
              '0, '0, 16383);
      set_row(5, "sat_neg", 2'd0, 2'd3, 18'h20000, 18'h20000, 12'h123,
              {6'd4, 6'd8, 6'd12}, {6'd4, 6'd8, 6'd12}, -16384);
      // random audio rows
      for (int i = 6; i < ROWS; i++) begin
         a = 18'($random(seed));
         b = 18'($random(seed));
         set_row(i, $sformatf("random_%0d", i), 2'd1, 2'd3, a, b, 12'h7e0,
                 {6'd29, 6'd59, 6'd0}, {6'd22, 6'd45, 6'd0}, ref_word(a, b, 2'd3));
      end
   endtask

   initial begin
      logic [17:0] got1;
      logic [17:0] got2;
      int          cyc;
      int          lines;
      int          hc;
      int          vl;
      errors           = 0;
      seed             = 91478;
      pll_lock         = 1'b0;
      ntscmode         = 1'b0;
      r_in             = '0;
      g_in             = '0;
      b_in             = '0;
      audio_l          = '0;
      audio_r          = '0;
      mcu_start        = 1'b0;
      mcu_osd_strobe   = 1'b0;
      mcu_data         = '0;
      system_scanlines = '0;
      system_volume    = '0;
      load_table();

      @(negedge clk);
      check_val("reset hp_ws", 0, hp_ws);
      check_val("reset hp_din", 0, hp_din);
      check_val("reset osd_status", 0, osd_status);
      check_val("reset lcd_bl", 0, lcd_bl);
      check_val("reset pa_en", 1, pa_en);
      repeat (2) @(negedge clk);
      pll_lock = 1'b1;

      // panel clock follows clk, backlight and amplifier come on
      @(posedge clk);
      #1;
      check_val("lcd_clk high", 1, lcd_clk);
      check_val("locked lcd_bl", 1, lcd_bl);
      check_val("locked pa_en", 0, pa_en);
      @(negedge clk);
      #1;
      check_val("lcd_clk low", 0, lcd_clk);

      for (int i = 0; i < ROWS; i++) begin
         @(negedge clk);
         system_scanlines = t_scan[i];
         system_volume    = t_vol[i];
         audio_l          = t_left[i];
         audio_r          = t_right[i];
         {r_in, g_in, b_in} = t_col[i];
         repeat (3) wait_edge(0, 1'b0, 1000, "input hsync");
         // first copy starts right after the input line start
         wait_edge(0, 1'b0, 1000, "input hsync");
         wait_edge(1, 1'b0, 400, "output hsync low");
         wait_edge(1, 1'b1, 400, "output hsync high");
         repeat (61) @(negedge clk);
         got1 = {lcd_r, lcd_g, lcd_b};
         wait_edge(1, 1'b1, 400, "output hsync high");
         repeat (61) @(negedge clk);
         got2 = {lcd_r, lcd_g, lcd_b};
         check_val({t_name[i], " first copy"}, t_exp1[i], got1);
         check_val({t_name[i], " second copy"}, t_exp2[i], got2);
         wait_words(3);
         check_val({t_name[i], " left"}, t_word[i], $signed(rx_left));
         check_val({t_name[i], " right"}, t_word[i], $signed(rx_right));
      end

      // osd window with an all ones first bitmap row
      @(negedge clk);
      system_scanlines = 2'd0;
      {r_in, g_in, b_in} = 12'h842;
      send_osd(8'h01, 0);
      wait_status(1'b1);
      send_osd(8'h02, 128);
      wait_edge(2, 1'b1, 20000, "output vsync");
      repeat (`OSD_Y0 + 1) wait_edge(1, 1'b1, 400, "output hsync");
      repeat (`OSD_X0 + 1) @(negedge clk);
      check_val("osd origin", {6'd63, 6'd63, 6'd63}, {lcd_r, lcd_g, lcd_b});
      // first pixel right of the window
      repeat (`OSD_W) @(negedge clk);
      check_val("osd outside", {6'd34, 6'd17, 6'd8}, {lcd_r, lcd_g, lcd_b});
      send_osd(8'h00, 0);
      wait_status(1'b0);

      // data enable counts for both standards
      for (int m = 0; m < 2; m++) begin
         @(negedge clk);
         ntscmode = m[0];
         wait_edge(2, 1'b1, 20000, "output vsync");
         measure_de(cyc, lines);
         hc = de_hits(m ? `DE_X_NTSC : `DE_X_PAL, H_TOTAL / 2, 2048, `DE_WIDTH);
         vl = de_hits(m ? `DE_Y_NTSC : `DE_Y_PAL, V_TOTAL * 2, 1024, `DE_HEIGHT);
         check_val(m ? "de cycles ntsc" : "de cycles pal", hc * vl, cyc);
         check_val(m ? "de lines ntsc" : "de lines pal", (hc > 0) ? vl : 0, lines);
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: video/lcd_de_gen.sv
// panel data enable
`timescale 1ns/1ps
`include "video_params.svh"

module lcd_de_gen (
   input  logic clk,
   input  logic ntscmode,
   input  logic hs_n,
   input  logic vs_n,
   output logic de
);
   localparam logic [10:0] X_PAL  = 11'(`DE_X_PAL);
   localparam logic [10:0] X_NTSC = 11'(`DE_X_NTSC);
   localparam logic [9:0]  Y_PAL  = 10'(`DE_Y_PAL);
   localparam logic [9:0]  Y_NTSC = 10'(`DE_Y_NTSC);
   localparam logic [10:0] WIDTH  = 11'(`DE_WIDTH);
   localparam logic [9:0]  HEIGHT = 10'(`DE_HEIGHT);

   logic [10:0] hcnt;
   logic [9:0]  vcnt;
   logic        last_hs_n;
   logic        last_vs_n;
   logic        hs_rise;

   assign hs_rise = hs_n && !last_hs_n;

   // preloads run past the wrap so the window starts some pixels in
   always_ff @(posedge clk) begin
      last_hs_n <= hs_n;
      if (hs_rise) begin
         hcnt      <= ntscmode ? X_NTSC : X_PAL;
         last_vs_n <= vs_n;
         if (vs_n && !last_vs_n) begin
            vcnt <= ntscmode ? Y_NTSC : Y_PAL;
         end else begin
            vcnt <= vcnt + 1'b1;
         end
      end else begin
         hcnt <= hcnt + 1'b1;
      end
   end

   assign de = (hcnt < WIDTH) && (vcnt < HEIGHT);

endmodule

// File: video/osd_overlay.sv
// osd bitmap overlay
`timescale 1ns/1ps
`include "video_params.svh"

module osd_overlay (
   input  logic       clk,
   input  logic       pll_lock,
   input  logic       data_in_start,
   input  logic       data_in_strobe,
   input  logic [7:0] data_in,
   pixel_if.snk       pix_in,
   pixel_if.src       pix_out,
   output logic       osd_status
);
   import video_pkg::*;

   localparam int BYTES = `OSD_W * `OSD_H / 8;
   localparam int AB    = $clog2(BYTES);
   localparam int XB    = $clog2(`OSD_W);
   localparam int YB    = $clog2(`OSD_H);
   localparam logic [10:0] X0 = 11'(`OSD_X0);
   localparam logic [10:0] X1 = 11'(`OSD_X0 + `OSD_W);
   localparam logic [9:0]  Y0 = 10'(`OSD_Y0);
   localparam logic [9:0]  Y1 = 10'(`OSD_Y0 + `OSD_H);

   logic [7:0]    bitmap [0:BYTES-1];
   osd_rx_state_t state;
   logic [AB-1:0] wr_addr;
   logic          enable;
   logic          bm_we;
   logic          last_hs_n;
   logic          last_vs_n;
   logic [10:0]   hpos;
   logic [9:0]    vpos;
   logic [10:0]   dx;
   logic [9:0]    dy;
   logic [7:0]    rd_byte;
   logic          in_win;

   // command decode, a new start aborts anything open
   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         state   <= RX_IDLE;
         enable  <= 1'b0;
         wr_addr <= '0;
      end else if (data_in_start) begin
         state <= RX_CMD;
      end else if (data_in_strobe) begin
         case (state)
            RX_CMD: begin
               state <= RX_IDLE;
               case (osd_cmd_t'(data_in))
                  OSD_CMD_DISABLE: enable <= 1'b0;
                  OSD_CMD_ENABLE:  enable <= 1'b1;
                  OSD_CMD_WRITE: begin
                     wr_addr <= '0;
                     state   <= RX_DATA;
                  end
                  default: ;
               endcase
            end
            RX_DATA: wr_addr <= wr_addr + 1'b1;
            default: ;
         endcase
      end
   end

   assign bm_we      = data_in_strobe && !data_in_start && (state == RX_DATA);
   assign osd_status = enable;

   always_ff @(posedge clk) begin
      if (bm_we) begin
         bitmap[wr_addr] <= data_in;
      end
   end

   // position from end of hsync and vsync, held at max past the line end
   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         last_hs_n <= 1'b1;
         last_vs_n <= 1'b1;
         hpos      <= '1;
         vpos      <= '1;
      end else begin
         last_hs_n <= pix_in.hs_n;
         if (pix_in.hs_n && !last_hs_n) begin
            hpos      <= '0;
            last_vs_n <= pix_in.vs_n;
            if (pix_in.vs_n && !last_vs_n) begin
               vpos <= '0;
            end else if (vpos != '1) begin
               vpos <= vpos + 1'b1;
            end
         end else if (hpos != '1) begin
            hpos <= hpos + 1'b1;
         end
      end
   end

   assign in_win  = enable && (hpos >= X0) && (hpos < X1) && (vpos >= Y0) && (vpos < Y1);
   assign dx      = hpos - X0;
   assign dy      = vpos - Y0;
   // eight pixels per byte, leftmost pixel in bit 7
   assign rd_byte = bitmap[{dy[YB-1:0], dx[XB-1:3]}];

   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         pix_out.hs_n <= 1'b1;
         pix_out.vs_n <= 1'b1;
      end else begin
         pix_out.hs_n <= pix_in.hs_n;
         pix_out.vs_n <= pix_in.vs_n;
      end
   end

   always_ff @(posedge clk) begin
      if (in_win && rd_byte[~dx[2:0]]) begin
         pix_out.r <= 6'h3f;
         pix_out.g <= 6'h3f;
         pix_out.b <= 6'h3f;
      end else if (in_win) begin
         pix_out.r <= pix_in.r >> 1;
         pix_out.g <= pix_in.g >> 1;
         pix_out.b <= pix_in.b >> 1;
      end else begin
         pix_out.r <= pix_in.r;
         pix_out.g <= pix_in.g;
         pix_out.b <= pix_in.b;
      end
   end

endmodule

// File: video/scandoubler.sv
// line doubler with scanlines
`timescale 1ns/1ps
`include "video_params.svh"

module scandoubler (
   input  logic                 clk,
   input  logic                 pll_lock,
   input  video_pkg::scanline_t scanlines,
   input  logic                 hs_in_n,
   input  logic                 vs_in_n,
   input  logic [3:0]           r_in,
   input  logic [3:0]           g_in,
   input  logic [3:0]           b_in,
   pixel_if.src                 pix_out
);
   import video_pkg::*;

   localparam int AW = `LINE_ADDR_W;

   // two lines of 12-bit rgb, msb of address picks the half
   logic [11:0]   line_buf [0:(2**(AW+1))-1];

   logic          ce;
   logic          last_hs_n;
   logic          line_sel;
   logic [AW-1:0] wr_addr;
   logic [AW-1:0] line_len;
   logic [AW-1:0] sync_len;
   logic [AW-1:0] rd_addr;
   logic          second;
   logic          hs_fall;
   logic          hs_rise;
   logic [AW:0]   wr_ptr;
   logic [11:0]   rd_pix;
   logic          vs_d;

   // expand 4 to 6 bits, then dim on the repeated line
   function automatic logic [5:0] shade(input logic [3:0] c, input logic dim,
                                        input scanline_t lvl);
      logic [5:0] e;
      e = {c, c[3:2]};
      if (!dim) begin
         shade = e;
      end else begin
         case (lvl)
            SCAN_25: shade = e - (e >> 2);
            SCAN_50: shade = e >> 1;
            SCAN_75: shade = e >> 2;
            default: shade = e;
         endcase
      end
   endfunction

   // input pixels arrive at half clk rate
   assign hs_fall = ce && last_hs_n && !hs_in_n;
   assign hs_rise = ce && !last_hs_n && hs_in_n;

   // first pixel of a new line goes to address 0 of the other half
   assign wr_ptr = hs_fall ? {~line_sel, {AW{1'b0}}} : {line_sel, wr_addr};

   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         ce        <= 1'b0;
         last_hs_n <= 1'b1;
         line_sel  <= 1'b0;
         wr_addr   <= '0;
         line_len  <= '0;
         sync_len  <= '0;
      end else begin
         ce <= ~ce;
         if (ce) begin
            last_hs_n <= hs_in_n;
            if (hs_fall) begin
               line_len <= wr_addr;
               line_sel <= ~line_sel;
               wr_addr  <= AW'(1);
            end else begin
               wr_addr <= wr_addr + 1'b1;
            end
            // pixels since start of sync
            if (hs_rise) begin
               sync_len <= wr_addr;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ce) begin
         line_buf[wr_ptr] <= {r_in, g_in, b_in};
      end
   end

   // read the finished half twice at full rate
   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         rd_addr <= '0;
         second  <= 1'b0;
      end else if (hs_fall) begin
         rd_addr <= '0;
         second  <= 1'b0;
      end else if (rd_addr == line_len - 1'b1) begin
         rd_addr <= '0;
         second  <= ~second;
      end else begin
         rd_addr <= rd_addr + 1'b1;
      end
   end

   assign rd_pix = line_buf[{~line_sel, rd_addr}];

   // hsync rebuilt from the measured sync width
   always_ff @(posedge clk or negedge pll_lock) begin
      if (!pll_lock) begin
         vs_d         <= 1'b1;
         pix_out.hs_n <= 1'b1;
         pix_out.vs_n <= 1'b1;
      end else begin
         vs_d         <= vs_in_n;
         pix_out.hs_n <= (rd_addr >= sync_len);
         pix_out.vs_n <= vs_d;
      end
   end

   always_ff @(posedge clk) begin
      pix_out.r <= shade(rd_pix[11:8], second, scanlines);
      pix_out.g <= shade(rd_pix[7:4], second, scanlines);
      pix_out.b <= shade(rd_pix[3:0], second, scanlines);
   end

endmodule
